// ==== design/geometry_pkg.sv ====
package geometry_pkg;

  // stored image is a square window in the top left of the camera frame
  localparam int IMG_DIM = 64;     // edge length in pixels
  localparam int COORD_W = 6;      // log2 of IMG_DIM
  localparam int ADDR_W = 12;      // two coordinates side by side

  // camera side counters are wider than the stored window
  localparam int IN_COORD_W = 11;

  // one coordinate inside the stored window
  typedef logic [COORD_W-1:0] coord_t;

  // buffer address, row * IMG_DIM + column
  // with a power of two edge this is just {row, col}
  typedef logic [ADDR_W-1:0] addr_t;

  // one flag per row or per column
  typedef logic [IMG_DIM-1:0] line_marks_t;

endpackage

// ==== design/scan_pkg.sv ====
package scan_pkg;

  // top FSM, encoded one-hot so the led view is the state itself
  localparam int STATE_W = 5;

  typedef enum logic [STATE_W-1:0] {
    RESET      = 5'b00001,
    STREAMING  = 5'b00010,   // frame buffer follows the camera
    HORIZ_SCAN = 5'b00100,   // row-major pass
    VERT_SCAN  = 5'b01000,   // column-major pass
    FINISHED   = 5'b10000    // marks are final
  } state_t;

  // direction of the pass a pixel belongs to
  typedef enum logic {
    HORIZ = 1'b0,
    VERT  = 1'b1
  } axis_t;

  // a run can span a whole line, so 0..64 must fit
  localparam int RUN_W = 7;
  typedef logic [RUN_W-1:0] run_t;

  // finder pattern is 1+1+3+1+1 modules wide
  localparam int RATIO_UNITS = 7;

  // frame buffer read path, memory stage plus output register
  localparam int READ_LATENCY = 2;

endpackage

// ==== design/pixel_stream_if.sv ====
interface pixel_stream_if;

  logic                   px_valid;    // px_bit holds a real pixel
  logic                   px_bit;      // 1 = dark
  geometry_pkg::coord_t   line_idx;    // row in the horiz pass, column in the vert pass
  logic                   line_last;   // final pixel of this line
  scan_pkg::axis_t        axis;        // which pass the pixel came from
  logic                   pass_done;   // one cycle pulse after the last pixel of a pass

  // address generator side
  modport gen (
    output px_valid, px_bit, line_idx, line_last, axis, pass_done
  );

  // ratio detector side
  modport det (
    input px_valid, px_bit, line_idx, line_last, axis, pass_done
  );

endinterface

// ==== design/pixel_binarizer.sv ====
module pixel_binarizer (
  input  logic                                  clk_pixel,
  input  logic                                  sys_rst,
  input  logic                                  pixel_valid,  // one cycle per pixel
  input  logic [15:0]                           pixel_data,   // rgb565
  input  logic [geometry_pkg::IN_COORD_W-1:0]   hcount,
  input  logic [geometry_pkg::IN_COORD_W-1:0]   vcount,
  input  logic [7:0]                            thresh,
  output logic                                  bin_valid,
  output logic                                  bin_bit,      // 1 = dark
  output logic [geometry_pkg::IN_COORD_W-1:0]   bin_h,
  output logic [geometry_pkg::IN_COORD_W-1:0]   bin_v
);

  logic [7:0] luma;
  logic       dark;

  // green carries most of the brightness, and it has the widest field
  // 6 bit green padded to 8 bits so it lines up with the threshold
  assign luma = {pixel_data[10:5], 2'b00};
  assign dark = (luma < thresh);   // strictly below counts as dark

  // strobe is control state
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      bin_valid <= 1'b0;
    end else begin
      bin_valid <= pixel_valid;
    end
  end

  // bit and coordinates ride along with the strobe
  always_ff @(posedge clk_pixel) begin
    bin_bit <= dark;
    bin_h   <= hcount;  // still full width, range test is in the buffer
    bin_v   <= vcount;
  end

endmodule

// ==== design/frame_buffer.sv ====
module frame_buffer (
  input  logic                                  clk_pixel,
  input  logic                                  sys_rst,
  input  logic                                  capture,     // high freezes the image
  input  logic                                  bin_valid,
  input  logic                                  bin_bit,
  input  logic [geometry_pkg::IN_COORD_W-1:0]   bin_h,
  input  logic [geometry_pkg::IN_COORD_W-1:0]   bin_v,
  input  logic                                  rd_en,
  input  geometry_pkg::addr_t                   rd_addr,
  output logic                                  rd_data
);

  // one bit per pixel of the stored window
  logic mem [geometry_pkg::IMG_DIM * geometry_pkg::IMG_DIM];

  logic                 wr_en;
  logic                 in_range;
  geometry_pkg::addr_t  wr_addr;
  logic                 rd_q;       // memory stage of the read path

  // camera frame is larger than the window so anything outside it is dropped
  assign in_range = (bin_h < geometry_pkg::IN_COORD_W'(geometry_pkg::IMG_DIM)) &&
                    (bin_v < geometry_pkg::IN_COORD_W'(geometry_pkg::IMG_DIM));

  assign wr_en   = bin_valid && !capture && in_range;
  assign wr_addr = {bin_v[geometry_pkg::COORD_W-1:0], bin_h[geometry_pkg::COORD_W-1:0]};

  // read-first so a same cycle write shows up on the next read only
  always_ff @(posedge clk_pixel) begin
    if (wr_en) begin
      mem[wr_addr] <= bin_bit;
    end
    if (rd_en) begin
      rd_q <= mem[rd_addr];   // cycle 1
    end
  end

  // output register adds the second cycle of the read latency
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      rd_data <= 1'b0;
    end else begin
      rd_data <= rd_q;
    end
  end

  // image stays frozen for the whole scan once capture is up
  a_no_write_in_capture : assert property (
    @(posedge clk_pixel) disable iff (sys_rst)
    capture |=> (mem[$past(wr_addr)] === $past(mem[wr_addr]))
  );

endmodule

// ==== design/scan_address_gen.sv ====
module scan_address_gen (
  input  logic                  clk_pixel,
  input  logic                  sys_rst,
  input  logic                  scan_go,    // one cycle, starts both passes
  output logic                  rd_en,
  output geometry_pkg::addr_t   rd_addr,
  pixel_stream_if.gen           stream,
  input  logic                  rd_data
);

  localparam geometry_pkg::coord_t LAST_IDX = geometry_pkg::coord_t'(geometry_pkg::IMG_DIM - 1);

  logic                  active;  // a pass is issuing reads
  scan_pkg::axis_t       axis;
  geometry_pkg::coord_t  line;    // row when horiz, column when vert
  geometry_pkg::coord_t  pos;     // position along the line
  logic                  pass_end;

  // tags for reads in flight, [0] is the newest
  logic [scan_pkg::READ_LATENCY-1:0]  valid_q;
  logic [scan_pkg::READ_LATENCY-1:0]  last_q;
  geometry_pkg::coord_t               line_q [scan_pkg::READ_LATENCY];
  scan_pkg::axis_t                    axis_q [scan_pkg::READ_LATENCY];
  logic [scan_pkg::READ_LATENCY:0]    end_q;  // one stage longer, pulse trails the data

  assign pass_end = active && (pos == LAST_IDX) && (line == LAST_IDX);

  // one read per cycle while a pass runs
  assign rd_en   = active;
  assign rd_addr = (axis == scan_pkg::HORIZ) ? {line, pos} : {pos, line};

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      active <= 1'b0;
      axis   <= scan_pkg::HORIZ;
      line   <= '0;
      pos    <= '0;
    end else if (!active) begin
      if (scan_go) begin
        active <= 1'b1;
        axis   <= scan_pkg::HORIZ;
        line   <= '0;
        pos    <= '0;
      end
    end else begin
      pos <= pos + 1'b1;          // wraps at IMG_DIM
      if (pos == LAST_IDX) begin
        line <= line + 1'b1;
        if (line == LAST_IDX) begin
          if (axis == scan_pkg::VERT) begin
            active <= 1'b0;       // both passes done
          end
          axis <= scan_pkg::VERT; // vert pass follows with no gap
        end
      end
    end
  end

  // control part of the tag pipeline
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      valid_q <= '0;
      end_q   <= '0;
    end else begin
      valid_q <= {valid_q[scan_pkg::READ_LATENCY-2:0], rd_en};
      end_q   <= {end_q[scan_pkg::READ_LATENCY-1:0], pass_end};
    end
  end

  // payload part, only meaningful where valid_q is set
  always_ff @(posedge clk_pixel) begin
    last_q    <= {last_q[scan_pkg::READ_LATENCY-2:0], pos == LAST_IDX};
    line_q[0] <= line;
    axis_q[0] <= axis;
    for (int i = 1; i < scan_pkg::READ_LATENCY; i++) begin
      line_q[i] <= line_q[i-1];
      axis_q[i] <= axis_q[i-1];
    end
  end

  assign stream.px_valid  = valid_q[scan_pkg::READ_LATENCY-1];
  assign stream.px_bit    = rd_data;    // already aligned by the buffer latency
  assign stream.line_idx  = line_q[scan_pkg::READ_LATENCY-1];
  assign stream.line_last = last_q[scan_pkg::READ_LATENCY-1];
  assign stream.axis      = axis_q[scan_pkg::READ_LATENCY-1];
  assign stream.pass_done = end_q[scan_pkg::READ_LATENCY];

  // reads only ever start as a response to the controller
  a_rd_start_on_go : assert property (
    @(posedge clk_pixel) disable iff (sys_rst)
    $rose(rd_en) |-> $past(scan_go)
  );

endmodule

// ==== design/ratio_detector.sv ====
module ratio_detector (
  input  logic                        clk_pixel,
  input  logic                        sys_rst,
  pixel_stream_if.det                 stream,
  output geometry_pkg::line_marks_t   row_marks,
  output geometry_pkg::line_marks_t   col_marks
);

  scan_pkg::run_t [3:0]  runs;      // completed runs on this line, [0] newest
  logic [2:0]            run_cnt;   // how many of runs are filled, stops at 4
  scan_pkg::run_t        cur_len;   // run in progress, 0 at line start
  logic                  cur_bit;   // colour of the run in progress

  logic                  line_start;
  logic                  brk;       // pixel closes the run in progress
  scan_pkg::run_t [3:0]  runs_nx;
  logic [2:0]            cnt_nx;
  scan_pkg::run_t        len_nx;
  scan_pkg::run_t [4:0]  cand;      // five runs under test, [0] newest and dark
  logic                  test_en;

  // x/t near 1/7 and c/t near 3/7, half a unit of slack either side
  // scaled by 2*RATIO_UNITS so everything stays integer
  function automatic logic ratio_ok(input scan_pkg::run_t [4:0] r);
    logic [10:0] t;
    logic [10:0] x14;
    logic        ok;
    int          i;
    t = '0;
    for (i = 0; i < 5; i++) begin
      t = t + 11'(r[i]);
    end
    ok = 1'b1;
    for (i = 0; i < 5; i++) begin
      x14 = 11'(r[i]) * 11'(2 * scan_pkg::RATIO_UNITS);
      if (i == 2) begin
        ok = ok && (x14 >= 11'd5 * t) && (x14 <= 11'd7 * t);  // center, 3 units
      end else begin
        ok = ok && (x14 >= t) && (x14 <= 11'd3 * t);          // outer, 1 unit
      end
    end
    return ok;
  endfunction

  always_comb begin
    line_start = (cur_len == '0);
    brk        = !line_start && (stream.px_bit != cur_bit);
    runs_nx    = brk ? {runs[2:0], cur_len} : runs;
    cnt_nx     = (brk && run_cnt != 3'd4) ? run_cnt + 3'd1 : run_cnt;
    len_nx     = (line_start || brk) ? scan_pkg::run_t'(1) : cur_len + 1'b1;

    // runs alternate, so a dark newest run means D L D L D
    if (stream.line_last && stream.px_bit) begin
      // dark run cut off by the line end, includes this pixel
      cand    = {runs_nx, len_nx};
      test_en = stream.px_valid && (cnt_nx == 3'd4);
    end else begin
      // dark run closed by a light pixel
      cand    = {runs, cur_len};
      test_en = stream.px_valid && brk && cur_bit && (run_cnt == 3'd4);
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      runs      <= '0;
      run_cnt   <= '0;
      cur_len   <= '0;
      cur_bit   <= 1'b0;
      row_marks <= '0;
      col_marks <= '0;
    end else if (stream.px_valid) begin
      if (stream.line_last) begin
        runs    <= '0;       // next line starts from scratch
        run_cnt <= '0;
        cur_len <= '0;
      end else begin
        runs    <= runs_nx;
        run_cnt <= cnt_nx;
        cur_len <= len_nx;
        cur_bit <= stream.px_bit;
      end

      if (test_en && ratio_ok(cand)) begin
        if (stream.axis == scan_pkg::HORIZ) begin
          row_marks[stream.line_idx] <= 1'b1;
        end else begin
          col_marks[stream.line_idx] <= 1'b1;
        end
      end
    end
  end

  // a pass must end on a line boundary of the generator
  a_pass_on_line_end : assert property (
    @(posedge clk_pixel) disable iff (sys_rst)
    stream.pass_done |-> (cur_len == '0)
  );

endmodule

// ==== design/scan_control.sv ====
module scan_control (
  input  logic                          clk_pixel,
  input  logic                          sys_rst,
  input  logic                          capture,
  input  logic                          start,
  input  logic                          pass_done,  // from the tail of the read pipeline
  output logic                          scan_go,
  output logic                          done,
  output logic [scan_pkg::STATE_W-1:0]  state_led
);

  scan_pkg::state_t state;

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      state   <= scan_pkg::RESET;
      scan_go <= 1'b0;
    end else begin
      scan_go <= 1'b0;   // pulse by default
      case (state)
        scan_pkg::RESET: begin
          state <= scan_pkg::STREAMING;
        end
        scan_pkg::STREAMING: begin
          // image is frozen and the user asked for a scan
          if (capture && start) begin
            state   <= scan_pkg::HORIZ_SCAN;
            scan_go <= 1'b1;
          end
        end
        scan_pkg::HORIZ_SCAN: begin
          if (pass_done) state <= scan_pkg::VERT_SCAN;
        end
        scan_pkg::VERT_SCAN: begin
          if (pass_done) state <= scan_pkg::FINISHED;
        end
        default: begin
          state <= state;  // FINISHED is left only through reset
        end
      endcase
    end
  end

  assign state_led = state;   // enum is one-hot already
  assign done      = (state == scan_pkg::FINISHED);

  a_led_onehot : assert property (
    @(posedge clk_pixel) disable iff (sys_rst)
    $onehot(state_led)
  );

  // a pass end seen outside the scan states would be lost
  a_pass_done_in_scan : assert property (
    @(posedge clk_pixel) disable iff (sys_rst)
    pass_done |-> (state == scan_pkg::HORIZ_SCAN || state == scan_pkg::VERT_SCAN)
  );

endmodule

// ==== design/qr_scan_top.sv ====
module qr_scan_top (
  input  logic                                  clk_pixel,
  input  logic                                  sys_rst,
  input  logic                                  pixel_valid,
  input  logic [15:0]                           pixel_data,  // rgb565
  input  logic [geometry_pkg::IN_COORD_W-1:0]   hcount,
  input  logic [geometry_pkg::IN_COORD_W-1:0]   vcount,
  input  logic [7:0]                            thresh,
  input  logic                                  capture,
  input  logic                                  start,
  output logic [scan_pkg::STATE_W-1:0]          state_led,
  output logic                                  done,
  output geometry_pkg::line_marks_t             row_marks,
  output geometry_pkg::line_marks_t             col_marks
);

  // binarized pixel, one cycle behind the camera side
  logic                                 bin_valid;
  logic                                 bin_bit;
  logic [geometry_pkg::IN_COORD_W-1:0]  bin_h;
  logic [geometry_pkg::IN_COORD_W-1:0]  bin_v;

  // scan read port
  logic                                 rd_en;
  geometry_pkg::addr_t                  rd_addr;
  logic                                 rd_data;

  logic                                 scan_go;

  pixel_stream_if stream ();  // generator to detector

  pixel_binarizer u_binarizer (
    .clk_pixel   (clk_pixel),
    .sys_rst     (sys_rst),
    .pixel_valid (pixel_valid),
    .pixel_data  (pixel_data),
    .hcount      (hcount),
    .vcount      (vcount),
    .thresh      (thresh),
    .bin_valid   (bin_valid),
    .bin_bit     (bin_bit),
    .bin_h       (bin_h),
    .bin_v       (bin_v)
  );

  frame_buffer u_frame_buffer (
    .clk_pixel (clk_pixel),
    .sys_rst   (sys_rst),
    .capture   (capture),
    .bin_valid (bin_valid),
    .bin_bit   (bin_bit),
    .bin_h     (bin_h),
    .bin_v     (bin_v),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  scan_address_gen u_addr_gen (
    .clk_pixel (clk_pixel),
    .sys_rst   (sys_rst),
    .scan_go   (scan_go),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .stream    (stream.gen),
    .rd_data   (rd_data)
  );

  ratio_detector u_detector (
    .clk_pixel (clk_pixel),
    .sys_rst   (sys_rst),
    .stream    (stream.det),
    .row_marks (row_marks),
    .col_marks (col_marks)
  );

  scan_control u_control (
    .clk_pixel (clk_pixel),
    .sys_rst   (sys_rst),
    .capture   (capture),
    .start     (start),
    .pass_done (stream.pass_done),  // same pulse the detector sees
    .scan_go   (scan_go),
    .done      (done),
    .state_led (state_led)
  );

endmodule

// ==== test/tb_qr_scan_top.sv ====
module tb_qr_scan_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_NS = 8;
  localparam int DIM = geometry_pkg::IMG_DIM;
  localparam int FRAME_W = 80;                          // camera frame wider than the window
  localparam int FRAME_H = 70;
  localparam int FRAME_CYC = 2 * FRAME_W * FRAME_H + 8; // one pixel plus at most one gap
  localparam int SCAN_CYC = 2 * DIM * DIM + 16;         // two passes and pipeline tail
  localparam int WATCHDOG_NS = (16 + 3 * FRAME_CYC + SCAN_CYC + 500) * CLK_NS;
  localparam int FINDER [9] = '{0, 1, 0, 1, 1, 1, 0, 1, 0};  // light border, 1:1:3:1:1, border

  logic clk_pixel, sys_rst, pixel_valid, capture, start, done;
  logic [15:0] pixel_data;
  logic [10:0] hcount, vcount;
  logic [7:0] thresh;
  logic [4:0] state_led, last_led;
  geometry_pkg::line_marks_t row_marks, col_marks;

  logic [63:0] img [64];       // model image, img[row][col]
  int          pat [64][64];   // -1 random, 0 light, 1 dark
  int          cur_thresh;
  logic [4:0]  led_seen [$];   // state_led changes once the monitor is on
  logic        monitor_on;
  int          seed_dummy;
  int          cyc;

  qr_scan_top dut (
    .clk_pixel(clk_pixel), .sys_rst(sys_rst), .pixel_valid(pixel_valid),
    .pixel_data(pixel_data), .hcount(hcount), .vcount(vcount), .thresh(thresh),
    .capture(capture), .start(start), .state_led(state_led), .done(done),
    .row_marks(row_marks), .col_marks(col_marks)
  );

  initial begin
    clk_pixel = 1'b0;
    forever #(CLK_NS / 2) clk_pixel = ~clk_pixel;
  end

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] time %0t: %s expected %0h actual %0h", $time, name, exp, got);
      abort_run();
    end
  endtask

  // three finder runs across rows, three down columns
  task automatic place_patterns();
    int i, k, unit, line, first;
    for (i = 0; i < DIM * DIM; i++) pat[i / DIM][i % DIM] = -1;
    for (k = 0; k < 6; k++) begin
      unit  = 1 + $urandom % 2;                  // 1,1,3,1,1 or 2,2,6,2,2
      line  = $urandom % DIM;
      first = $urandom % (DIM - 9 * unit + 1);
      for (i = 0; i < 9 * unit; i++) begin
        if (k < 3) pat[line][first + i] = FINDER[i / unit];
        else pat[first + i][line] = FINDER[i / unit];
      end
    end
  endtask

  // one full camera frame, model follows the write rules
  task automatic stream_frame(input bit frozen);
    int v, h, g, dark_max, light_min;
    dark_max  = (cur_thresh - 1) / 4;   // 4*g < thresh
    light_min = (cur_thresh + 3) / 4;   // 4*g >= thresh
    capture <= frozen;
    thresh  <= 8'(cur_thresh);
    for (v = 0; v < FRAME_H; v++) begin
      for (h = 0; h < FRAME_W; h++) begin
        if ($urandom % 4 == 0) begin
          pixel_valid <= 1'b0;          // idle gap
          @(posedge clk_pixel);
        end
        g = $urandom % 64;
        if (v < DIM && h < DIM && pat[v][h] == 1) g = $urandom % (dark_max + 1);
        if (v < DIM && h < DIM && pat[v][h] == 0) g = light_min + $urandom % (64 - light_min);
        pixel_valid <= 1'b1;
        pixel_data  <= {5'($urandom), 6'(g), 5'($urandom)};
        hcount      <= 11'(h);
        vcount      <= 11'(v);
        if (!frozen && v < DIM && h < DIM) img[v][h] = (g * 4 < cur_thresh);
        @(posedge clk_pixel);
      end
    end
    pixel_valid <= 1'b0;
    repeat (4) @(posedge clk_pixel);    // let the last write land
  endtask

  // dark runs closing a D L D L D group near 1:1:3:1:1
  function automatic logic finder_in_line(input logic [63:0] px);
    int len [64];
    logic clr [64];
    int n, p, k, j, t;
    logic ok, hit;
    n = 0;
    hit = 1'b0;
    for (p = 0; p < DIM; p++) begin
      if (p == 0 || px[p] != px[p-1]) begin
        clr[n] = px[p];
        len[n] = 1;
        n++;
      end else begin
        len[n-1]++;
      end
    end
    for (k = 4; k < n; k++) begin
      t  = len[k] + len[k-1] + len[k-2] + len[k-3] + len[k-4];
      ok = clr[k] && (14 * len[k-2] >= 5 * t) && (14 * len[k-2] <= 7 * t);
      for (j = 0; j < 5; j++) begin
        if (j != 2) ok = ok && (14 * len[k-j] >= t) && (14 * len[k-j] <= 3 * t);
      end
      hit = hit || ok;
    end
    return hit;
  endfunction

  function automatic geometry_pkg::line_marks_t model_marks(input bit vert);
    geometry_pkg::line_marks_t m;
    logic [63:0] px;
    int l, p;
    for (l = 0; l < DIM; l++) begin
      for (p = 0; p < DIM; p++) px[p] = vert ? img[p][l] : img[l][p];
      m[l] = finder_in_line(px);
    end
    return m;
  endfunction

  // records every state_led change after reset
  always @(negedge clk_pixel) begin
    if (monitor_on && state_led !== last_led) led_seen.push_back(state_led);
    last_led = state_led;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the run took longer than three frames and a scan");
    abort_run();
  end

  initial begin
    seed_dummy = $urandom(59726);
    sys_rst = 1'b1;
    pixel_valid = 1'b0;
    pixel_data = '0;
    hcount = '0;
    vcount = '0;
    thresh = 8'd128;
    capture = 1'b0;
    start = 1'b0;
    monitor_on = 1'b0;
    repeat (16) @(posedge clk_pixel);
    sys_rst <= 1'b0;
    repeat (2) @(posedge clk_pixel);   // RESET shows for one cycle
    @(negedge clk_pixel);
    check_value("state_led", state_led, scan_pkg::STREAMING);
    check_value("done", done, 0);
    check_value("row_marks", row_marks, 0);
    check_value("col_marks", col_marks, 0);
    @(posedge clk_pixel);
    monitor_on <= 1'b1;
    repeat (2) begin                   // the second frame is the one scanned
      cur_thresh = 16 + $urandom % 224;
      place_patterns();
      stream_frame(1'b0);
      @(negedge clk_pixel);
      check_value("state_led", state_led, scan_pkg::STREAMING);
      @(posedge clk_pixel);
    end
    cur_thresh = 16 + $urandom % 224;  // frozen buffer, this frame is dropped
    place_patterns();
    stream_frame(1'b1);
    start <= 1'b1;
    cyc = 0;
    while (done !== 1'b1 && cyc < SCAN_CYC) begin
      @(negedge clk_pixel);
      cyc++;
    end
    assert (done === 1'b1) else begin
      $display("done did not rise within %0d cycles after start", SCAN_CYC);
      abort_run();
    end
    check_value("row_marks", row_marks, model_marks(1'b0));
    check_value("col_marks", col_marks, model_marks(1'b1));
    repeat (20) @(negedge clk_pixel);  // FINISHED must hold
    check_value("done", done, 1);
    check_value("state_led", state_led, scan_pkg::FINISHED);
    assert (led_seen.size() == 3) else begin
      $display("state_led changed %0d times after reset, three expected", led_seen.size());
      abort_run();
    end
    check_value("state_led step 1", led_seen[0], scan_pkg::HORIZ_SCAN);
    check_value("state_led step 2", led_seen[1], scan_pkg::VERT_SCAN);
    check_value("state_led step 3", led_seen[2], scan_pkg::FINISHED);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== qr_scan_top.f ====
design/geometry_pkg.sv
design/scan_pkg.sv
design/pixel_stream_if.sv
design/pixel_binarizer.sv
design/frame_buffer.sv
design/scan_address_gen.sv
design/ratio_detector.sv
design/scan_control.sv
design/qr_scan_top.sv
test/tb_qr_scan_top.sv

// ==== Bender.yml ====
package:
  name: qr_scan

sources:
  - design/geometry_pkg.sv
  - design/scan_pkg.sv
  - design/pixel_stream_if.sv
  - design/pixel_binarizer.sv
  - design/frame_buffer.sv
  - design/scan_address_gen.sv
  - design/ratio_detector.sv
  - design/scan_control.sv
  - design/qr_scan_top.sv
  - target: test
    files:
      - test/tb_qr_scan_top.sv
